/* all.f */
hm_pkg.sv
hm_rx_fsm.sv
hm_rx_counter.sv
hm_bank_writer.sv
hm_dw_ram.sv
hm_rx_top.sv
hm_rx_assertions.sv
tb_hm_rx.sv

/* hm_bank_writer.sv */
`default_nettype none

module hm_bank_writer
  import hm_pkg::*;
#(
  parameter int unsigned bank_addr_w = 10
) (
  input  logic                   trn_clk,
  input  logic                   reset,
  input  logic                   beat_wr,
  input  logic                   beat_last,
  input  logic                   first_data,
  input  logic                   flush,
  input  logic                   trn_rrem_n,
  input  beat_t                  trn_rd,
  output logic                   mem_l_we,
  output logic                   mem_h_we,
  output logic [bank_addr_w-1:0] mem_l_addr,
  output logic [bank_addr_w-1:0] mem_h_addr,
  output dword_t                 mem_l_data,
  output dword_t                 mem_h_data
);

  // TRN delivers dwords big-endian, banks hold them little-endian
  function automatic dword_t byte_rev(input dword_t d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  logic [bank_addr_w-1:0] offset_l;
  logic [bank_addr_w-1:0] offset_h;
  logic                   odd;
  logic                   up_v;
  logic                   lo_v;
  logic                   two_dw;
  dword_t                 first_dw;
  dword_t                 second_dw;
  logic                   wr_l;
  logic                   wr_h;
  dword_t                 data_l;
  dword_t                 data_h;

  // Offsets differ by one after an odd number of payload dwords
  assign odd = offset_l[0] ^ offset_h[0];

  // Upper dword is header dword 2 on the first data beat
  assign up_v   = !first_data;
  // Lower dword is absent on a short end beat
  assign lo_v   = !(beat_last && trn_rrem_n);
  assign two_dw = up_v && lo_v;

  assign first_dw  = up_v ? byte_rev(trn_rd[63:32]) : byte_rev(trn_rd[31:0]);
  assign second_dw = byte_rev(trn_rd[31:0]);

  always_comb begin
    wr_l   = 1'b0;
    wr_h   = 1'b0;
    data_l = second_dw;
    data_h = second_dw;
    if (beat_wr && (up_v || lo_v)) begin
      if (!odd) begin
        wr_l   = 1'b1;
        data_l = first_dw;
        wr_h   = two_dw;
      end else begin
        wr_h   = 1'b1;
        data_h = first_dw;
        wr_l   = two_dw;
      end
    end
  end

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      mem_l_we <= 1'b0;
      mem_h_we <= 1'b0;
      offset_l <= '0;
      offset_h <= '0;
    end else begin
      mem_l_we <= wr_l;
      mem_h_we <= wr_h;
      // Offsets run on across completions until the read ends
      if (flush) begin
        offset_l <= '0;
        offset_h <= '0;
      end else begin
        if (wr_l) offset_l <= offset_l + 1'b1;
        if (wr_h) offset_h <= offset_h + 1'b1;
      end
    end
  end

  always_ff @(posedge trn_clk) begin
    if (wr_l) begin
      mem_l_addr <= offset_l;
      mem_l_data <= data_l;
    end
    if (wr_h) begin
      mem_h_addr <= offset_h;
      mem_h_data <= data_h;
    end
  end

endmodule

`default_nettype wire

/* hm_dw_ram.sv */
`default_nettype none

module hm_dw_ram
  import hm_pkg::*;
#(
  parameter int unsigned bank_addr_w = 10
) (
  input  logic                   trn_clk,
  input  logic                   we,
  input  logic [bank_addr_w-1:0] waddr,
  input  logic [bank_addr_w-1:0] raddr,
  input  dword_t                 wdata,
  output dword_t                 rdata
);

  localparam int unsigned depth = 2 ** bank_addr_w;

  dword_t mem [depth];

  always_ff @(posedge trn_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read data follows the address by one cycle
  always_ff @(posedge trn_clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

/* hm_pkg.sv */
`default_nettype none

package hm_pkg;

  // One TRN dword, as held in a bank
  typedef logic [31:0] dword_t;

  // One 64-bit TRN data beat, upper dword first in TLP order
  typedef logic [63:0] beat_t;

  // Remaining-byte field of a completion header
  typedef logic [11:0] byte_count_t;

  // Dword length field of a TLP header
  typedef logic [9:0] dw_len_t;

  // Received-TLP statistics counter
  typedef logic [31:0] stat_count_t;

  // Receive states, exported on stat_state
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RECV  = 2'd1,
    IGN   = 2'd2,
    FLUSH = 2'd3
  } rx_state_t;

  // Memory read completion with data (CplD)
  localparam logic [1:0] cpl_fmt  = 2'b10;
  localparam logic [4:0] cpl_type = 5'b01010;

endpackage

`default_nettype wire

/* hm_rx_assertions.sv */
`default_nettype none

module hm_rx_assertions
  import hm_pkg::*;
(
  input logic        trn_clk,
  input logic        reset,
  input logic        read_done,
  input rx_state_t   stat_state,
  input stat_count_t stat_trn_cpt_rx,
  input dword_t      rd_data_l,
  input dword_t      rd_data_h,
  input stat_count_t exp_cnt,
  input logic        done_allowed,
  input logic        chk_l,
  input logic        chk_h,
  input dword_t      exp_l,
  input dword_t      exp_h
);

  timeunit 1ns;
  timeprecision 1ps;

  int err_cnt = 0;

  // read_done only at the end of the last completion of a read
  a_done_expected: assert property (@(posedge trn_clk) disable iff (reset)
    read_done |-> done_allowed)
    else begin
      err_cnt++;
      $error("read_done pulsed while no read was ending");
    end

  a_done_pulse: assert property (@(posedge trn_clk) disable iff (reset)
    read_done |=> !read_done)
    else begin
      err_cnt++;
      $error("read_done stayed high for more than one cycle");
    end

  // State passes through FLUSH with the done pulse, then back to IDLE
  a_done_flush: assert property (@(posedge trn_clk) disable iff (reset)
    read_done |-> (stat_state == FLUSH))
    else begin
      err_cnt++;
      $error("CHECK FAILED stat_state: got %h expected %h", $sampled(stat_state), FLUSH);
    end

  a_flush_idle: assert property (@(posedge trn_clk) disable iff (reset)
    read_done |=> (stat_state == IDLE))
    else begin
      err_cnt++;
      $error("CHECK FAILED stat_state: got %h expected %h", $sampled(stat_state), IDLE);
    end

  a_count: assert property (@(posedge trn_clk) disable iff (reset)
    stat_trn_cpt_rx == exp_cnt)
    else begin
      err_cnt++;
      $error("CHECK FAILED stat_trn_cpt_rx: got %h expected %h",
             $sampled(stat_trn_cpt_rx), $sampled(exp_cnt));
    end

  // Values seen in the first cycle out of reset
  a_reset_state: assert property (@(posedge trn_clk)
    $fell(reset) |-> (!read_done && (stat_trn_cpt_rx == '0) && (stat_state == IDLE)))
    else begin
      err_cnt++;
      $error("Outputs did not return to their reset values after reset");
    end

  a_rd_l: assert property (@(posedge trn_clk) chk_l |-> (rd_data_l == exp_l))
    else begin
      err_cnt++;
      $error("CHECK FAILED rd_data_l: got %08h expected %08h",
             $sampled(rd_data_l), $sampled(exp_l));
    end

  a_rd_h: assert property (@(posedge trn_clk) chk_h |-> (rd_data_h == exp_h))
    else begin
      err_cnt++;
      $error("CHECK FAILED rd_data_h: got %08h expected %08h",
             $sampled(rd_data_h), $sampled(exp_h));
    end

endmodule

`default_nettype wire

/* hm_rx_counter.sv */
`default_nettype none

module hm_rx_counter
  import hm_pkg::*;
(
  input  logic        trn_clk,
  input  logic        reset,
  input  logic        hdr_load,
  input  logic        tlp_end,
  input  logic        beat_wr,
  input  beat_t       trn_rd,
  output logic        first_data,
  output logic        last_cpl,
  output stat_count_t stat_trn_cpt_rx
);

  byte_count_t byte_cnt;
  dw_len_t     len;
  // Data beats taken in the current completion
  dw_len_t     beat_idx;

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      byte_cnt        <= '0;
      len             <= '0;
      beat_idx        <= '0;
      stat_trn_cpt_rx <= '0;
    end else begin
      if (hdr_load) begin
        // Byte count from header dword 1, length from header dword 0
        byte_cnt <= trn_rd[11:0];
        len      <= trn_rd[41:32];
        beat_idx <= '0;
      end else if (beat_wr && (beat_idx != '1)) begin
        beat_idx <= beat_idx + 1'b1;
      end

      if (tlp_end) begin
        stat_trn_cpt_rx <= stat_trn_cpt_rx + 1'b1;
      end
    end
  end

  // Next data beat still holds header dword 2
  assign first_data = (beat_idx == '0);

  // Remaining bytes all fit in this completion
  // Zero length and zero byte count both mean the 4 KB maximum
  assign last_cpl = (byte_cnt == {len, 2'b00});

endmodule

`default_nettype wire

/* hm_rx_fsm.sv */
`default_nettype none

module hm_rx_fsm
  import hm_pkg::*;
(
  input  logic      trn_clk,
  input  logic      reset,
  input  beat_t     trn_rd,
  input  logic      trn_rsof_n,
  input  logic      trn_reof_n,
  input  logic      trn_rsrc_rdy_n,
  input  logic      last_cpl,
  output logic      hdr_load,
  output logic      tlp_end,
  output logic      beat_wr,
  output logic      beat_last,
  output logic      flush,
  output logic      read_done,
  output rx_state_t stat_state
);

  rx_state_t  state;
  rx_state_t  state_nxt;
  logic       beat_valid;
  logic       is_sof;
  logic       is_eof;
  logic       is_cpl;
  logic [1:0] fmt;
  logic [4:0] tlp_type;

  // Cycles with trn_rsrc_rdy_n high are gaps
  assign beat_valid = !trn_rsrc_rdy_n;
  assign is_sof     = beat_valid && !trn_rsof_n;
  assign is_eof     = beat_valid && !trn_reof_n;

  // Header dword 0 sits in the upper half of the start beat
  assign fmt      = trn_rd[62:61];
  assign tlp_type = trn_rd[60:56];
  assign is_cpl   = (fmt == cpl_fmt) && (tlp_type == cpl_type);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // A single-beat TLP carries no payload and stays here
        if (is_sof && !is_eof) begin
          if (is_cpl) begin
            state_nxt = RECV;
          end else begin
            state_nxt = IGN;
          end
        end
      end
      RECV: begin
        if (is_eof) begin
          state_nxt = last_cpl ? FLUSH : IDLE;
        end
      end
      IGN: begin
        if (is_eof) begin
          state_nxt = IDLE;
        end
      end
      FLUSH: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge trn_clk) begin
    if (reset) begin
      state     <= IDLE;
      read_done <= 1'b0;
    end else begin
      state     <= state_nxt;
      // Last completion of the read has ended
      read_done <= (state == RECV) && is_eof && last_cpl;
    end
  end

  // Header latch only for completions that carry data beats
  assign hdr_load = (state == IDLE) && is_sof && !is_eof && is_cpl;

  assign tlp_end = is_eof &&
                   ((state == RECV) || (state == IGN) || ((state == IDLE) && is_sof));

  // Every valid beat after the start beat holds payload
  assign beat_wr   = (state == RECV) && beat_valid;
  assign beat_last = beat_wr && !trn_reof_n;

  assign flush      = (state == FLUSH);
  assign stat_state = state;

endmodule

`default_nettype wire

/* hm_rx_top.sv */
`default_nettype none

module hm_rx_top
  import hm_pkg::*;
#(
  parameter int unsigned bank_addr_w = 10
) (
  input  logic                   trn_clk,
  input  logic                   reset,
  input  beat_t                  trn_rd,
  input  logic                   trn_rrem_n,
  input  logic                   trn_rsof_n,
  input  logic                   trn_reof_n,
  input  logic                   trn_rsrc_rdy_n,
  input  logic [bank_addr_w-1:0] rd_addr,
  output logic                   read_done,
  output stat_count_t            stat_trn_cpt_rx,
  output rx_state_t              stat_state,
  output dword_t                 rd_data_l,
  output dword_t                 rd_data_h
);

  logic                   hdr_load;
  logic                   tlp_end;
  logic                   beat_wr;
  logic                   beat_last;
  logic                   flush;
  logic                   first_data;
  logic                   last_cpl;
  logic                   mem_l_we;
  logic                   mem_h_we;
  logic [bank_addr_w-1:0] mem_l_addr;
  logic [bank_addr_w-1:0] mem_h_addr;
  dword_t                 mem_l_data;
  dword_t                 mem_h_data;

  hm_rx_fsm u_fsm (
    .trn_clk        (trn_clk),
    .reset          (reset),
    .trn_rd         (trn_rd),
    .trn_rsof_n     (trn_rsof_n),
    .trn_reof_n     (trn_reof_n),
    .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
    .last_cpl       (last_cpl),
    .hdr_load       (hdr_load),
    .tlp_end        (tlp_end),
    .beat_wr        (beat_wr),
    .beat_last      (beat_last),
    .flush          (flush),
    .read_done      (read_done),
    .stat_state     (stat_state)
  );

  hm_rx_counter u_counter (
    .trn_clk         (trn_clk),
    .reset           (reset),
    .hdr_load        (hdr_load),
    .tlp_end         (tlp_end),
    .beat_wr         (beat_wr),
    .trn_rd          (trn_rd),
    .first_data      (first_data),
    .last_cpl        (last_cpl),
    .stat_trn_cpt_rx (stat_trn_cpt_rx)
  );

  hm_bank_writer #(.bank_addr_w(bank_addr_w)) u_writer (
    .trn_clk    (trn_clk),
    .reset      (reset),
    .beat_wr    (beat_wr),
    .beat_last  (beat_last),
    .first_data (first_data),
    .flush      (flush),
    .trn_rrem_n (trn_rrem_n),
    .trn_rd     (trn_rd),
    .mem_l_we   (mem_l_we),
    .mem_h_we   (mem_h_we),
    .mem_l_addr (mem_l_addr),
    .mem_h_addr (mem_h_addr),
    .mem_l_data (mem_l_data),
    .mem_h_data (mem_h_data)
  );

  // Even payload dwords
  hm_dw_ram #(.bank_addr_w(bank_addr_w)) bank_l (
    .trn_clk (trn_clk),
    .we      (mem_l_we),
    .waddr   (mem_l_addr),
    .raddr   (rd_addr),
    .wdata   (mem_l_data),
    .rdata   (rd_data_l)
  );

  // Odd payload dwords
  hm_dw_ram #(.bank_addr_w(bank_addr_w)) bank_h (
    .trn_clk (trn_clk),
    .we      (mem_h_we),
    .waddr   (mem_h_addr),
    .raddr   (rd_addr),
    .wdata   (mem_h_data),
    .rdata   (rd_data_h)
  );

endmodule

`default_nettype wire

/* tb_hm_rx.sv */
`default_nettype none

module tb_hm_rx
  import hm_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int bank_addr_w  = 10;
  localparam int depth        = 2 ** bank_addr_w;
  localparam int done_timeout = 200;

  logic                   trn_clk;
  logic                   reset;
  beat_t                  trn_rd;
  logic                   trn_rrem_n;
  logic                   trn_rsof_n;
  logic                   trn_reof_n;
  logic                   trn_rsrc_rdy_n;
  logic [bank_addr_w-1:0] rd_addr;
  logic                   read_done;
  stat_count_t            stat_trn_cpt_rx;
  rx_state_t              stat_state;
  dword_t                 rd_data_l;
  dword_t                 rd_data_h;

  // Expectations seen by the bound checker
  stat_count_t exp_cnt;
  logic        done_allowed;
  logic        chk_l;
  logic        chk_h;
  dword_t      exp_l;
  dword_t      exp_h;

  // Payload dword k is modelled in bank k mod 2 at address k/2
  dword_t model_l [depth];
  dword_t model_h [depth];
  int     model_k;
  int     fill_l;
  int     fill_h;

  int          tb_errs;
  int          prev_errs;
  int          tests_passed;
  int          tests_failed;

  hm_rx_top #(.bank_addr_w(bank_addr_w)) dut (
    .trn_clk         (trn_clk),
    .reset           (reset),
    .trn_rd          (trn_rd),
    .trn_rrem_n      (trn_rrem_n),
    .trn_rsof_n      (trn_rsof_n),
    .trn_reof_n      (trn_reof_n),
    .trn_rsrc_rdy_n  (trn_rsrc_rdy_n),
    .rd_addr         (rd_addr),
    .read_done       (read_done),
    .stat_trn_cpt_rx (stat_trn_cpt_rx),
    .stat_state      (stat_state),
    .rd_data_l       (rd_data_l),
    .rd_data_h       (rd_data_h)
  );

  bind hm_rx_top hm_rx_assertions chk (
    .trn_clk         (trn_clk),
    .reset           (reset),
    .read_done       (read_done),
    .stat_state      (stat_state),
    .stat_trn_cpt_rx (stat_trn_cpt_rx),
    .rd_data_l       (rd_data_l),
    .rd_data_h       (rd_data_h),
    .exp_cnt         (tb_hm_rx.exp_cnt),
    .done_allowed    (tb_hm_rx.done_allowed),
    .chk_l           (tb_hm_rx.chk_l),
    .chk_h           (tb_hm_rx.chk_h),
    .exp_l           (tb_hm_rx.exp_l),
    .exp_h           (tb_hm_rx.exp_h)
  );

  always #20 trn_clk = ~trn_clk;

  function automatic dword_t swap_bytes(input dword_t d);
    dword_t r;
    r = {<<8{d}};
    return r;
  endfunction

  function automatic dword_t cpl_hdr0(input int n_dw);
    return {1'b0, cpl_fmt, cpl_type, 14'h0, n_dw[9:0]};
  endfunction

  // Completer ID, status and the remaining byte count
  function automatic dword_t cpl_hdr1(input int bytes);
    return {16'h0100, 4'h0, bytes[11:0]};
  endfunction

  task automatic idle_inputs();
    trn_rsrc_rdy_n = 1'b1;
    trn_rsof_n     = 1'b1;
    trn_reof_n     = 1'b1;
    trn_rrem_n     = 1'b0;
  endtask

  task automatic store_payload(input dword_t d);
    if (model_k % 2 == 0) begin
      model_l[model_k / 2] = swap_bytes(d);
      if (model_k / 2 + 1 > fill_l) fill_l = model_k / 2 + 1;
    end else begin
      model_h[model_k / 2] = swap_bytes(d);
      if (model_k / 2 + 1 > fill_h) fill_h = model_k / 2 + 1;
    end
    model_k++;
  endtask

  // Sends a 3DW-header TLP in beats of two dwords with the upper one first
  task automatic send_tlp(input dword_t hdr0, input dword_t hdr1, input int n_pay,
                          input bit store, input bit gaps);
    dword_t q[$];
    dword_t d;
    int     nb;
    int     b;
    int     i;
    q.push_back(hdr0);
    q.push_back(hdr1);
    q.push_back($urandom());
    for (i = 0; i < n_pay; i++) begin
      d = $urandom();
      q.push_back(d);
      if (store) store_payload(d);
    end
    nb = (q.size() + 1) / 2;
    for (b = 0; b < nb; b++) begin
      if (gaps && b > 0) begin
        repeat ($urandom() % 4) begin
          @(negedge trn_clk);
          idle_inputs();
          trn_rd = {$urandom(), $urandom()};
        end
      end
      @(negedge trn_clk);
      trn_rsrc_rdy_n = 1'b0;
      trn_rsof_n     = (b != 0);
      trn_reof_n     = (b != nb - 1);
      trn_rrem_n     = (b == nb - 1) && (q.size() % 2 == 1);
      trn_rd[63:32]  = q[2 * b];
      trn_rd[31:0]   = (2 * b + 1 < q.size()) ? q[2 * b + 1] : $urandom();
    end
    @(negedge trn_clk);
    idle_inputs();
    exp_cnt = exp_cnt + 1;
  endtask

  task automatic wait_done();
    int  i;
    bit  seen;
    seen = 1'b0;
    for (i = 0; i < done_timeout && !seen; i++) begin
      if (read_done) seen = 1'b1;
      else @(negedge trn_clk);
    end
    if (!seen) begin
      tb_errs++;
      $display("ERROR: read_done did not arrive within %0d cycles", done_timeout);
    end
    @(negedge trn_clk);
    done_allowed = 1'b0;
    model_k      = 0;
  endtask

  // Last completion of a read when its bytes cover all that remain
  task automatic send_cpl(input int n_dw, input int remaining_dw, input bit gaps);
    send_tlp(cpl_hdr0(n_dw), cpl_hdr1(remaining_dw * 4), n_dw, 1'b1, gaps);
    // Done pulse of the ending read is sampled on the next rising edge
    if (n_dw == remaining_dw) begin
      done_allowed = 1'b1;
      wait_done();
    end
  endtask

  // Checks trail the address by one step as read data lags it by one cycle
  task automatic readback();
    int n;
    int a;
    n = (fill_l > fill_h) ? fill_l : fill_h;
    for (a = 0; a <= n; a++) begin
      @(negedge trn_clk);
      chk_l = (a > 0) && (a - 1 < fill_l);
      chk_h = (a > 0) && (a - 1 < fill_h);
      if (a > 0) begin
        exp_l = model_l[a - 1];
        exp_h = model_h[a - 1];
      end
      rd_addr = a[bank_addr_w-1:0];
    end
    @(negedge trn_clk);
    chk_l = 1'b0;
    chk_h = 1'b0;
  endtask

  task automatic apply_reset();
    reset        = 1'b1;
    idle_inputs();
    exp_cnt      = '0;
    model_k      = 0;
    done_allowed = 1'b0;
    repeat (3) @(posedge trn_clk);
    @(negedge trn_clk);
    reset = 1'b0;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = dut.chk.err_cnt + tb_errs;
    if (errs == prev_errs) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errs - prev_errs);
    end
    prev_errs = errs;
  endtask

  initial begin
    trn_clk      = 1'b0;
    reset        = 1'b1;
    trn_rd       = '0;
    rd_addr      = '0;
    exp_cnt      = '0;
    done_allowed = 1'b0;
    chk_l        = 1'b0;
    chk_h        = 1'b0;
    exp_l        = '0;
    exp_h        = '0;
    model_k      = 0;
    fill_l       = 0;
    fill_h       = 0;
    tb_errs      = 0;
    prev_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    idle_inputs();
    void'($urandom(32'he4a5));
    apply_reset();

    send_cpl(7, 7, 1'b0);
    readback();
    end_test("single completion");

    send_cpl(6, 11, 1'b0);
    send_cpl(5, 5, 1'b0);
    readback();
    end_test("split read");

    send_cpl(8, 13, 1'b1);
    send_cpl(5, 5, 1'b1);
    readback();
    end_test("source gaps");

    // Memory writes and completions without data between completions
    send_tlp({1'b0, 2'b10, 5'b00000, 14'h0, 10'd4}, $urandom(), 4, 1'b0, 1'b0);
    send_tlp({1'b0, 2'b00, cpl_type, 14'h0, 10'd0}, $urandom(), 0, 1'b0, 1'b0);
    send_cpl(3, 8, 1'b0);
    send_tlp({1'b0, 2'b10, 5'b00000, 14'h0, 10'd2}, $urandom(), 2, 1'b0, 1'b0);
    send_tlp({1'b0, 2'b00, cpl_type, 14'h0, 10'd0}, $urandom(), 0, 1'b0, 1'b0);
    send_cpl(5, 5, 1'b0);
    readback();
    end_test("non-completion TLPs");

    send_cpl(4, 4, 1'b0);
    readback();
    end_test("done pulse and flush");

    // Reset lands after the start beat of a completion
    send_cpl(4, 10, 1'b0);
    @(negedge trn_clk);
    trn_rsrc_rdy_n = 1'b0;
    trn_rsof_n     = 1'b0;
    trn_reof_n     = 1'b1;
    trn_rd         = {cpl_hdr0(6), cpl_hdr1(24)};
    @(negedge trn_clk);
    apply_reset();
    send_cpl(6, 6, 1'b0);
    readback();
    end_test("reset inside a TLP");

    $display("Summary: %0d tests passed, %0d failed, %0d errors",
             tests_passed, tests_failed, prev_errs);
    if (tests_failed == 0 && prev_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
